// File: hdl/vec_store_pkg.sv
package vec_store_pkg;

  // vector geometry
  localparam int VLEN = 4;

  // memory window, byte address of word 0 and depth in words
  localparam logic [31:0] MEM_BASE = 32'hA000_0000;
  localparam int MEM_WORDS = 256;

  // extra attempts after an error response
  localparam int MAX_RETRY = 2;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;
  typedef logic [VLEN*32-1:0] vec_t;
  typedef logic [1:0] resp_t;
  typedef logic [7:0] len_t;
  typedef logic [$clog2(VLEN)-1:0] beat_t;
  typedef logic [$clog2(MAX_RETRY+1)-1:0] retry_t;
  typedef logic [$clog2(MEM_WORDS)-1:0] index_t;

  // axi response codes
  localparam resp_t RESP_OKAY = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;

  // burst shape, 4 bytes per beat and incrementing addresses
  localparam logic [2:0] AXI_SIZE_4B = 3'b010;
  localparam logic [1:0] AXI_BURST_INCR = 2'b01;
  localparam beat_t LAST_BEAT = beat_t'(VLEN - 1);

  // what a client hands over with req
  typedef struct packed {
    addr_t addr;
    vec_t  data;
  } write_req_t;

  typedef struct packed {
    addr_t      addr;
    len_t       len;
    logic [2:0] size;
    logic [1:0] burst;
  } axi_aw_t;

  typedef struct packed {
    word_t data;
    logic  last;
  } axi_w_t;

  typedef enum logic [2:0] {IDLE, ADDR, DATA, RESP, DONE} writer_state_t;

endpackage

// File: hdl/vector_writer.sv
`timescale 1ns/1ps

module vector_writer (
  input  logic                      clk,
  input  logic                      reset,
  // client side, four-phase req/ack
  input  logic                      req,
  input  vec_store_pkg::write_req_t wreq,
  output logic                      ack,
  output logic                      error,
  // axi write address channel
  output vec_store_pkg::axi_aw_t    aw,
  output logic                      aw_valid,
  input  logic                      aw_ready,
  // axi write data channel
  output vec_store_pkg::axi_w_t     w,
  output logic                      w_valid,
  input  logic                      w_ready,
  // axi write response channel
  input  vec_store_pkg::resp_t      b_resp,
  input  logic                      b_valid,
  output logic                      b_ready
);
  import vec_store_pkg::*;

  writer_state_t state;
  write_req_t    req_q;
  beat_t         beat;
  retry_t        retry_cnt;

  // request is captured once, retries resend the same vector
  always_ff @(posedge clk) begin
    if (state == IDLE && req) begin
      req_q <= wreq;
    end
  end

  // burst header, one burst carries the whole vector
  assign aw.addr  = req_q.addr;
  assign aw.len   = len_t'(VLEN - 1);
  assign aw.size  = AXI_SIZE_4B;
  assign aw.burst = AXI_BURST_INCR;

  // current beat taken from the latched vector, word 0 first
  assign w.data = req_q.data[32*beat +: 32];
  assign w.last = (beat == LAST_BEAT);

  // channel strobes follow the phase directly
  assign aw_valid = (state == ADDR);
  assign w_valid  = (state == DATA);
  assign b_ready  = (state == RESP);
  assign ack      = (state == DONE);

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= IDLE;
      beat      <= '0;
      retry_cnt <= '0;
      error     <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          // new request, fresh retry budget
          if (req) begin
            state     <= ADDR;
            retry_cnt <= '0;
            error     <= 1'b0;
          end
        end
        ADDR: begin
          if (aw_ready) begin
            state <= DATA;
            beat  <= '0;
          end
        end
        DATA: begin
          // one beat per cycle while the slave takes data
          if (w_ready) begin
            if (w.last) begin
              state <= RESP;
            end else begin
              beat <= beat + 1'b1;
            end
          end
        end
        RESP: begin
          if (b_valid) begin
            if (b_resp == RESP_OKAY) begin
              state <= DONE;
              error <= 1'b0;
            end else if (retry_cnt == retry_t'(MAX_RETRY)) begin
              // budget used up, report failure to the client
              state <= DONE;
              error <= 1'b1;
            end else begin
              // resend the whole burst
              state     <= ADDR;
              retry_cnt <= retry_cnt + 1'b1;
            end
          end
        end
        DONE: begin
          // ack drops the cycle after the client lets go of req
          if (!req) begin
            state <= IDLE;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // address offer is held, with its payload, until the slave takes it
  assert property (@(posedge clk) disable iff (reset)
    aw_valid && !aw_ready |=> aw_valid && $stable(aw));

  // last only once the data phase has run for vlen cycles
  assert property (@(posedge clk) disable iff (reset)
    w_valid && w_ready && w.last |-> $past(w_valid) && $past(w_valid, VLEN - 1));

endmodule

// File: hdl/axi_write_arbiter.sv
`timescale 1ns/1ps

module axi_write_arbiter (
  input  logic                   clk,
  input  logic                   reset,
  // writer 0 side
  input  vec_store_pkg::axi_aw_t wr0_aw,
  input  logic                   wr0_aw_valid,
  output logic                   wr0_aw_ready,
  input  vec_store_pkg::axi_w_t  wr0_w,
  input  logic                   wr0_w_valid,
  output logic                   wr0_w_ready,
  output vec_store_pkg::resp_t   wr0_b_resp,
  output logic                   wr0_b_valid,
  input  logic                   wr0_b_ready,
  // writer 1 side
  input  vec_store_pkg::axi_aw_t wr1_aw,
  input  logic                   wr1_aw_valid,
  output logic                   wr1_aw_ready,
  input  vec_store_pkg::axi_w_t  wr1_w,
  input  logic                   wr1_w_valid,
  output logic                   wr1_w_ready,
  output vec_store_pkg::resp_t   wr1_b_resp,
  output logic                   wr1_b_valid,
  input  logic                   wr1_b_ready,
  // memory side
  output vec_store_pkg::axi_aw_t aw,
  output logic                   aw_valid,
  input  logic                   aw_ready,
  output vec_store_pkg::axi_w_t  w,
  output logic                   w_valid,
  input  logic                   w_ready,
  input  vec_store_pkg::resp_t   b_resp,
  input  logic                   b_valid,
  output logic                   b_ready
);
  import vec_store_pkg::*;

  // one-hot grant, bit n for writer n
  logic [1:0] grant_q;
  logic [1:0] grant_new;
  logic [1:0] grant;
  logic       last_served;
  // set between an aw transfer and its b transfer
  logic       in_burst;

  always_comb begin
    grant_new = 2'b00;
    if (grant_q == 2'b00) begin
      if (wr0_aw_valid && wr1_aw_valid) begin
        // both waiting, the one not served last goes first
        grant_new = last_served ? 2'b01 : 2'b10;
      end else if (wr0_aw_valid) begin
        grant_new = 2'b01;
      end else if (wr1_aw_valid) begin
        grant_new = 2'b10;
      end
    end
  end

  // a fresh grant acts in the cycle it is decided
  assign grant = (grant_q != 2'b00) ? grant_q : grant_new;

  always_ff @(posedge clk) begin
    if (reset) begin
      grant_q     <= 2'b00;
      last_served <= 1'b0;
      in_burst    <= 1'b0;
    end else begin
      // held until the write response, freed the cycle after
      if (b_valid && b_ready) begin
        grant_q <= 2'b00;
      end else if (grant_q == 2'b00 && grant_new != 2'b00) begin
        grant_q     <= grant_new;
        last_served <= grant_new[1];
      end
      if (aw_valid && aw_ready) begin
        in_burst <= 1'b1;
      end else if (b_valid && b_ready) begin
        in_burst <= 1'b0;
      end
    end
  end

  // granted writer onto the memory
  assign aw       = grant[1] ? wr1_aw : wr0_aw;
  assign aw_valid = (grant[0] & wr0_aw_valid) | (grant[1] & wr1_aw_valid);
  assign w        = grant[1] ? wr1_w : wr0_w;
  assign w_valid  = (grant[0] & wr0_w_valid) | (grant[1] & wr1_w_valid);
  assign b_ready  = (grant[0] & wr0_b_ready) | (grant[1] & wr1_b_ready);

  // waiting writer sees aw_ready low and keeps its offer up
  assign wr0_aw_ready = grant[0] & aw_ready;
  assign wr0_w_ready  = grant[0] & w_ready;
  assign wr0_b_valid  = grant[0] & b_valid;
  assign wr0_b_resp   = grant[0] ? b_resp : RESP_OKAY;
  assign wr1_aw_ready = grant[1] & aw_ready;
  assign wr1_w_ready  = grant[1] & w_ready;
  assign wr1_b_valid  = grant[1] & b_valid;
  assign wr1_b_resp   = grant[1] ? b_resp : RESP_OKAY;

  // only one writer is past its address phase at a time
  assert property (@(posedge clk) disable iff (reset)
    !((wr0_w_valid || wr0_b_ready) && (wr1_w_valid || wr1_b_ready)));

  // bus owner is fixed for the whole burst
  assert property (@(posedge clk) disable iff (reset) in_burst |-> $stable(grant));

endmodule

// File: hdl/word_memory.sv
`timescale 1ns/1ps

module word_memory (
  input  logic                   clk,
  input  logic                   reset,
  // axi write address channel
  input  vec_store_pkg::axi_aw_t aw,
  input  logic                   aw_valid,
  output logic                   aw_ready,
  // axi write data channel
  input  vec_store_pkg::axi_w_t  w,
  input  logic                   w_valid,
  output logic                   w_ready,
  // axi write response channel
  output vec_store_pkg::resp_t   b_resp,
  output logic                   b_valid,
  input  logic                   b_ready,
  // combinational read port
  input  vec_store_pkg::index_t  rd_index,
  output vec_store_pkg::word_t   rd_data
);
  import vec_store_pkg::*;

  word_t  ram [MEM_WORDS];

  // a burst is open from aw transfer to b transfer
  logic   busy;
  len_t   beat_cnt;
  // burst context captured on the aw transfer
  len_t   len_q;
  index_t wr_idx;
  logic   in_range_q;

  addr_t  offset;
  logic   aw_in_range;

  // word offset of the burst start inside the window
  assign offset = (aw.addr - MEM_BASE) >> 2;

  // aligned, not below the base and last word still inside
  assign aw_in_range = (aw.addr[1:0] == 2'b00) && (aw.addr >= MEM_BASE) &&
                       ((offset + addr_t'(aw.len)) < addr_t'(MEM_WORDS));

  assign aw_ready = !busy;
  assign b_resp   = in_range_q ? RESP_OKAY : RESP_SLVERR;
  assign rd_data  = ram[rd_index];

  always_ff @(posedge clk) begin
    if (reset) begin
      busy     <= 1'b0;
      w_ready  <= 1'b0;
      b_valid  <= 1'b0;
      beat_cnt <= '0;
    end else begin
      if (aw_valid && aw_ready) begin
        busy     <= 1'b1;
        w_ready  <= 1'b1;
        beat_cnt <= '0;
      end
      if (w_valid && w_ready) begin
        beat_cnt <= beat_cnt + 1'b1;
        // response follows the last beat by one cycle
        if (w.last) begin
          w_ready <= 1'b0;
          b_valid <= 1'b1;
        end
      end
      if (b_valid && b_ready) begin
        b_valid <= 1'b0;
        busy    <= 1'b0;
      end
    end
  end

  // latch the burst start and its range verdict
  always_ff @(posedge clk) begin
    if (aw_valid && aw_ready) begin
      len_q      <= aw.len;
      wr_idx     <= index_t'(offset);
      in_range_q <= aw_in_range;
    end else if (w_valid && w_ready) begin
      wr_idx <= wr_idx + 1'b1;
    end
  end

  // out-of-range bursts are drained without touching the ram
  always_ff @(posedge clk) begin
    if (w_valid && w_ready && in_range_q) begin
      ram[wr_idx] <= w.data;
    end
  end

  // last flag agrees with the length announced on aw
  assert property (@(posedge clk) disable iff (reset)
    w_valid && w_ready |-> (w.last == (beat_cnt == len_q)));

endmodule

// File: hdl/vec_store_top.sv
`timescale 1ns/1ps

module vec_store_top (
  input  logic                      clk,
  input  logic                      reset,
  // client 0
  input  logic                      req0,
  input  vec_store_pkg::write_req_t wreq0,
  output logic                      ack0,
  output logic                      error0,
  // client 1
  input  logic                      req1,
  input  vec_store_pkg::write_req_t wreq1,
  output logic                      ack1,
  output logic                      error1,
  // memory read-back
  input  vec_store_pkg::index_t     rd_index,
  output vec_store_pkg::word_t      rd_data
);
  import vec_store_pkg::*;

  // writer 0 to arbiter
  axi_aw_t wr0_aw;
  logic    wr0_aw_valid;
  logic    wr0_aw_ready;
  axi_w_t  wr0_w;
  logic    wr0_w_valid;
  logic    wr0_w_ready;
  resp_t   wr0_b_resp;
  logic    wr0_b_valid;
  logic    wr0_b_ready;

  // writer 1 to arbiter
  axi_aw_t wr1_aw;
  logic    wr1_aw_valid;
  logic    wr1_aw_ready;
  axi_w_t  wr1_w;
  logic    wr1_w_valid;
  logic    wr1_w_ready;
  resp_t   wr1_b_resp;
  logic    wr1_b_valid;
  logic    wr1_b_ready;

  // shared bus, arbiter to memory
  axi_aw_t mem_aw;
  logic    mem_aw_valid;
  logic    mem_aw_ready;
  axi_w_t  mem_w;
  logic    mem_w_valid;
  logic    mem_w_ready;
  resp_t   mem_b_resp;
  logic    mem_b_valid;
  logic    mem_b_ready;

  vector_writer u_writer0 (
    .clk      (clk),
    .reset    (reset),
    .req      (req0),
    .wreq     (wreq0),
    .ack      (ack0),
    .error    (error0),
    .aw       (wr0_aw),
    .aw_valid (wr0_aw_valid),
    .aw_ready (wr0_aw_ready),
    .w        (wr0_w),
    .w_valid  (wr0_w_valid),
    .w_ready  (wr0_w_ready),
    .b_resp   (wr0_b_resp),
    .b_valid  (wr0_b_valid),
    .b_ready  (wr0_b_ready)
  );

  vector_writer u_writer1 (
    .clk      (clk),
    .reset    (reset),
    .req      (req1),
    .wreq     (wreq1),
    .ack      (ack1),
    .error    (error1),
    .aw       (wr1_aw),
    .aw_valid (wr1_aw_valid),
    .aw_ready (wr1_aw_ready),
    .w        (wr1_w),
    .w_valid  (wr1_w_valid),
    .w_ready  (wr1_w_ready),
    .b_resp   (wr1_b_resp),
    .b_valid  (wr1_b_valid),
    .b_ready  (wr1_b_ready)
  );

  axi_write_arbiter u_arbiter (
    .clk          (clk),
    .reset        (reset),
    .wr0_aw       (wr0_aw),
    .wr0_aw_valid (wr0_aw_valid),
    .wr0_aw_ready (wr0_aw_ready),
    .wr0_w        (wr0_w),
    .wr0_w_valid  (wr0_w_valid),
    .wr0_w_ready  (wr0_w_ready),
    .wr0_b_resp   (wr0_b_resp),
    .wr0_b_valid  (wr0_b_valid),
    .wr0_b_ready  (wr0_b_ready),
    .wr1_aw       (wr1_aw),
    .wr1_aw_valid (wr1_aw_valid),
    .wr1_aw_ready (wr1_aw_ready),
    .wr1_w        (wr1_w),
    .wr1_w_valid  (wr1_w_valid),
    .wr1_w_ready  (wr1_w_ready),
    .wr1_b_resp   (wr1_b_resp),
    .wr1_b_valid  (wr1_b_valid),
    .wr1_b_ready  (wr1_b_ready),
    .aw           (mem_aw),
    .aw_valid     (mem_aw_valid),
    .aw_ready     (mem_aw_ready),
    .w            (mem_w),
    .w_valid      (mem_w_valid),
    .w_ready      (mem_w_ready),
    .b_resp       (mem_b_resp),
    .b_valid      (mem_b_valid),
    .b_ready      (mem_b_ready)
  );

  word_memory u_memory (
    .clk      (clk),
    .reset    (reset),
    .aw       (mem_aw),
    .aw_valid (mem_aw_valid),
    .aw_ready (mem_aw_ready),
    .w        (mem_w),
    .w_valid  (mem_w_valid),
    .w_ready  (mem_w_ready),
    .b_resp   (mem_b_resp),
    .b_valid  (mem_b_valid),
    .b_ready  (mem_b_ready),
    .rd_index (rd_index),
    .rd_data  (rd_data)
  );

endmodule

// File: bench/vec_store_tb.sv
`timescale 1ns/1ps

module vec_store_tb;
  import vec_store_pkg::*;

  // one request line from the vectors file
  typedef struct packed {
    logic  client;
    addr_t addr;
    vec_t  data;
    logic  err;
  } vec_line_t;

  logic       clk = 1'b0;
  logic       reset;
  logic [1:0] req;
  write_req_t wreq [2];
  logic [1:0] ack;
  logic [1:0] error;
  logic [1:0] ack_prev;
  index_t     rd_index;
  word_t      rd_data;

  vec_line_t  lines [$];
  word_t      model [MEM_WORDS];
  bit         written [MEM_WORDS];
  logic [31:0] lfsr_state = 32'he910_5582;
  int         cycles = 0;
  int         limit = 0;

  vec_store_top dut (
    .clk      (clk),
    .reset    (reset),
    .req0     (req[0]),
    .wreq0    (wreq[0]),
    .ack0     (ack[0]),
    .error0   (error[0]),
    .req1     (req[1]),
    .wreq1    (wreq[1]),
    .ack1     (ack[1]),
    .error1   (error[1]),
    .rd_index (rd_index),
    .rd_data  (rd_data)
  );

  always #5 clk = ~clk;

  task automatic stop_with_failure();
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("Fail at time %0t: %s, got %0h expected %0h", $time, what, actual, expected);
      stop_with_failure();
    end
  endtask

  // galois lfsr, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // 0 to 3 cycles, two bits taken one step each
  function automatic int random_delay();
    int d;
    d = 0;
    for (int b = 0; b < 2; b++) begin
      lfsr_state = lfsr_step(lfsr_state);
      d = (d << 1) | int'(lfsr_state[0]);
    end
    return d;
  endfunction

  // expected memory contents follow only the requests that should succeed
  task automatic update_model(input vec_line_t ln);
    int idx;
    if (!ln.err) begin
      idx = int'((ln.addr - MEM_BASE) >> 2);
      for (int k = 0; k < VLEN; k++) begin
        model[idx + k] = ln.data[32*k +: 32];
        written[idx + k] = 1'b1;
      end
    end
  endtask

  // full four-phase handshake on one client port
  task automatic run_request(input vec_line_t ln, input int drop_delay);
    int c;
    c = int'(ln.client);
    @(posedge clk);
    wreq[c].addr <= ln.addr;
    wreq[c].data <= ln.data;
    req[c] <= 1'b1;
    do @(posedge clk); while (!ack[c]);
    check_value(32'(error[c]), 32'(ln.err), $sformatf("error flag, client %0d addr %h", c, ln.addr));
    // ack has to stay up while req is still held
    repeat (drop_delay) begin
      @(posedge clk);
      check_value(32'(ack[c]), 32'd1, $sformatf("ack dropped before req, client %0d", c));
    end
    req[c] <= 1'b0;
    do @(posedge clk); while (ack[c]);
  endtask

  // ack must never rise with req low
  always @(posedge clk) begin
    if (!reset) begin
      for (int c = 0; c < 2; c++) begin
        if (ack[c] && !ack_prev[c]) begin
          check_value(32'(req[c]), 32'd1, $sformatf("ack rose while req low, client %0d", c));
        end
      end
    end
    ack_prev <= ack;
  end

  // run limit, set once the request count is known
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (limit != 0 && cycles >= limit) begin
      $display("run timed out waiting for ack after %0d cycles", cycles);
      stop_with_failure();
    end
  end

  initial begin
    int fd;
    int cl;
    int ev;
    int i;
    int d0;
    int d1;
    string line;
    logic [31:0] a;
    logic [31:0] w0;
    logic [31:0] w1;
    logic [31:0] w2;
    logic [31:0] w3;
    reset = 1'b1;
    req = 2'b00;
    wreq[0] = '0;
    wreq[1] = '0;
    rd_index = '0;
    ack_prev = 2'b00;
    fd = $fopen("bench/vec_store_vectors.txt", "r");
    if (fd == 0) begin
      $display("could not open bench/vec_store_vectors.txt");
      stop_with_failure();
    end
    // comment lines start with #, anything that does not parse is skipped
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() > 0 && line[0] != "#") begin
        if ($sscanf(line, "%d %h %h %h %h %h %d", cl, a, w0, w1, w2, w3, ev) == 7) begin
          lines.push_back({cl[0], a, {w3, w2, w1, w0}, ev[0]});
        end
      end
    end
    $fclose(fd);
    limit = lines.size() * (VLEN + 6) * (MAX_RETRY + 1) * 2 + 200;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    // pairs with one line per client start in the same cycle
    i = 0;
    while (i < lines.size()) begin
      if (i + 1 < lines.size() && lines[i].client != lines[i+1].client) begin
        d0 = random_delay();
        d1 = random_delay();
        fork
          run_request(lines[i], d0);
          run_request(lines[i+1], d1);
        join
        update_model(lines[i]);
        update_model(lines[i+1]);
        i += 2;
      end else begin
        d0 = random_delay();
        run_request(lines[i], d0);
        update_model(lines[i]);
        i += 1;
      end
    end
    // read back every word that a good request wrote
    for (int k = 0; k < MEM_WORDS; k++) begin
      if (written[k]) begin
        @(posedge clk);
        rd_index <= index_t'(k);
        @(negedge clk);
        check_value(rd_data, model[k], $sformatf("memory word %0d", k));
      end
    end
    $display("PASS: all tests");
    $finish;
  end

endmodule

// File: bench/vec_store_vectors.txt
# client address data0 data1 data2 data3 error, address and data in hex
# two neighbouring lines for different clients are started in the same cycle
0 a0000000 11110000 11110001 11110002 11110003 0
0 a0000020 12120000 12120001 12120002 12120003 0
1 a0000040 21210000 21210001 21210002 21210003 0
1 a0000050 22220000 22220001 22220002 22220003 0
0 a0000100 31310000 31310001 31310002 31310003 0
1 a0000200 32320000 32320001 32320002 32320003 0
0 a00003f0 41410000 41410001 41410002 41410003 0
1 a0000080 42420000 42420001 42420002 42420003 0
0 a00003f8 deadbe00 deadbe01 deadbe02 deadbe03 1
1 a0000300 52520000 52520001 52520002 52520003 0
0 9ffffff0 0badf000 0badf001 0badf002 0badf003 1
1 a00003fc 0bad0000 0bad0001 0bad0002 0bad0003 1
0 a0000000 71710000 71710001 71710002 71710003 0
1 a0000200 72720000 72720001 72720002 72720003 0
0 a0000002 0bada000 0bada001 0bada002 0bada003 1
1 a00003f0 82820000 82820001 82820002 82820003 0

// File: verilog.f
hdl/vec_store_pkg.sv
hdl/vector_writer.sv
hdl/axi_write_arbiter.sv
hdl/word_memory.sv
hdl/vec_store_top.sv
bench/vec_store_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run from the project root, pass is decided from the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f verilog.f --top-module vec_store_tb \
  -o vec_store_sim > sim.log 2>&1 &&
  ./obj_dir/vec_store_sim >> sim.log 2>&1
grep -q "^PASS: all tests" sim.log && echo "simulation passed" ||
  { echo "simulation failed, see sim.log"; exit 1; }
